// ==== md_cfg.svh ====
// Configuration macros for the multiply/divide unit
// Sets the data width, the multiply pipeline depth and the immediate width

`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// Width of both operands and of the result word
`define MD_WIDTH 32

// Number of register stages in the multiply pipeline
// It must be at least one more than the number of 16-bit operand chunks
`define MD_MUL_STAGES 4

// Width of the immediate field in the immediate instruction form
`define MD_IMM_WIDTH 28

`endif

// ==== mdIsaPkg.sv ====
// Instruction encoding for the multiply/divide unit
// Opcodes, function codes and the two views of the instruction word

`include "md_cfg.svh"

package mdIsaPkg;

	// ====================
	// Opcode and function codes
	// ====================

	// Major opcode held in the top nibble of every instruction
	typedef enum logic [3:0] {
		OP_R2    = 4'h0,
		OP_MULI  = 4'h1,
		OP_MULUI = 4'h2,
		OP_DIVI  = 4'h3,
		OP_DIVUI = 4'h4
	} mdOpcode;

	// Function selector, only meaningful for the register form
	typedef enum logic [3:0] {
		F_MUL   = 4'h0,
		F_MULH  = 4'h1,
		F_MULHU = 4'h2,
		F_DIV   = 4'h3,
		F_DIVU  = 4'h4,
		F_REM   = 4'h5,
		F_REMU  = 4'h6
	} mdFunc;

	// Which datapath an operation runs on
	typedef enum logic [1:0] {
		K_MUL = 2'd0,
		K_DIV = 2'd1
	} mdKind;

	// ====================
	// Instruction word
	// ====================

	// Register form with the function in the second nibble
	typedef struct packed {
		mdOpcode     opcode;
		mdFunc       func;
		logic [23:0] rsvd;
	} mdRegForm;

	// Immediate form where the immediate replaces operand b
	typedef struct packed {
		mdOpcode                   opcode;
		logic [`MD_IMM_WIDTH-1:0] imm;
	} mdImmForm;

	// The same 32-bit word is decoded both ways
	typedef union packed {
		mdRegForm regForm;
		mdImmForm immForm;
	} mdInstr;

endpackage

// ==== mdDataPkg.sv ====
// Data bundles passed between the blocks of the multiply/divide unit
// Covers the incoming operands, the prepared operands and the result

`include "md_cfg.svh"

package mdDataPkg;

	// Instruction and both register operands as presented with start
	typedef struct packed {
		mdIsaPkg::mdInstr      instr;
		logic [`MD_WIDTH-1:0] a;
		logic [`MD_WIDTH-1:0] b;
	} mdOperands;

	// Operands after decode, immediate selection and sign removal
	typedef struct packed {
		mdIsaPkg::mdKind       kind;
		logic [`MD_WIDTH-1:0] a;
		logic [`MD_WIDTH-1:0] b;
		logic                  resSign;
		logic                  remSign;
		logic                  takeHigh;
		logic                  takeRem;
		logic                  isSigned;
		logic                  divZero;
	} mdPrepared;

	// Result word with its two status flags
	typedef struct packed {
		logic [`MD_WIDTH-1:0] value;
		logic                  ovf;
		logic                  dvByZr;
	} mdResult;

endpackage

// ==== mdSequencer.sv ====
// Sequencer for the multiply/divide unit
// Steps through prepare, compute and finish and strobes the datapath loads

`timescale 1ns/1ns
`include "md_cfg.svh"

module mdSequencer (
	input  logic            clk,
	input  logic            arstN,
	input  logic            start,
	input  logic            prepZero,
	input  mdIsaPkg::mdKind kind,
	input  logic            last,
	output logic            prepLoad,
	output logic            cntLoad,
	output logic            mulLoad,
	output logic            divLoad,
	output logic            divStep,
	output logic [5:0]      cntInit,
	output logic            busy,
	output logic            done
);
	import mdIsaPkg::*;

	typedef enum logic [1:0] {sIdle, sPrep, sCompute, sFinish} seqState;

	seqState state;
	seqState stateNext;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			state <= sIdle;
		else
			state <= stateNext;
	end

	always_comb
	begin
		stateNext = state;
		prepLoad  = 1'b0;
		cntLoad   = 1'b0;
		mulLoad   = 1'b0;
		divLoad   = 1'b0;
		divStep   = 1'b0;
		cntInit   = 6'(`MD_MUL_STAGES);
		case (state)
		sIdle:
			begin
				// A start is only seen here, so a start while busy is dropped
				if (start)
				begin
					prepLoad  = 1'b1;
					stateNext = sPrep;
				end
			end
		sPrep:
			begin
				// Divide by zero needs no iterations and goes straight to finish
				if (prepZero)
					stateNext = sFinish;
				else
				begin
					cntLoad   = 1'b1;
					stateNext = sCompute;
					if (kind == K_MUL)
						mulLoad = 1'b1;
					else
					begin
						divLoad = 1'b1;
						cntInit = 6'(`MD_WIDTH);
					end
				end
			end
		sCompute:
			begin
				// The divider takes one quotient bit on every compute cycle
				divStep = (kind == K_DIV);
				if (last)
					stateNext = sFinish;
			end
		default:
			stateNext = sIdle;
		endcase
	end

	assign busy = (state != sIdle);
	assign done = (state == sFinish);

endmodule

// ==== mdCycleCounter.sv ====
// Down-counter that times the compute phase
// Flags the final compute cycle when the count reaches one

`timescale 1ns/1ns

module mdCycleCounter (
	input  logic       clk,
	input  logic       arstN,
	input  logic       cntLoad,
	input  logic [5:0] cntInit,
	output logic       last
);

	logic [5:0] cnt;

	// Loads the cycle budget, then counts down and parks at zero
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			cnt <= '0;
		else if (cntLoad)
			cnt <= cntInit;
		else if (cnt != 6'd0)
			cnt <= cnt - 6'd1;
	end

	// The cycle holding a count of one is the last compute cycle
	assign last = (cnt == 6'd1);

endmodule

// ==== mdOperandPrep.sv ====
// Operand preparation for the multiply/divide unit
// Decodes the instruction, picks the b operand and removes the operand signs

`timescale 1ns/1ns
`include "md_cfg.svh"

module mdOperandPrep (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  prepLoad,
	input  mdDataPkg::mdOperands ops,
	output mdDataPkg::mdPrepared prep,
	output logic                  prepZero
);
	import mdIsaPkg::*;
	import mdDataPkg::*;

	// Decoded control bits for one instruction
	typedef struct packed {
		logic isDiv;
		logic isSigned;
		logic takeHigh;
		logic takeRem;
	} decFlags;

	decFlags               dec;
	mdPrepared             nxt;
	logic [`MD_WIDTH-1:0] immExt;
	logic [`MD_WIDTH-1:0] opB;
	logic                  aNeg;
	logic                  bNeg;

	// Register form decoded through the func field
	always_comb
	begin
		case (ops.instr.regForm.opcode)
		OP_R2:
			case (ops.instr.regForm.func)
			F_MUL:   dec = 4'b0100;
			F_MULH:  dec = 4'b0110;
			F_MULHU: dec = 4'b0010;
			F_DIV:   dec = 4'b1100;
			F_DIVU:  dec = 4'b1000;
			F_REM:   dec = 4'b1101;
			F_REMU:  dec = 4'b1001;
			default: dec = 4'b0000;
			endcase
		OP_MULI:  dec = 4'b0100;
		OP_DIVI:  dec = 4'b1100;
		OP_DIVUI: dec = 4'b1000;
		default:  dec = 4'b0000;
		endcase
	end

	// Immediate view, extended according to the signedness of the operation
	assign immExt = {{(`MD_WIDTH-`MD_IMM_WIDTH){dec.isSigned & ops.instr.immForm.imm[`MD_IMM_WIDTH-1]}},
		ops.instr.immForm.imm};
	assign opB = (ops.instr.immForm.opcode == OP_R2) ? ops.b : immExt;

	// Sign bits only count for the signed forms
	assign aNeg = dec.isSigned & ops.a[`MD_WIDTH-1];
	assign bNeg = dec.isSigned & opB[`MD_WIDTH-1];

	always_comb
	begin
		nxt.kind     = dec.isDiv ? K_DIV : K_MUL;
		nxt.a        = aNeg ? -ops.a : ops.a;
		nxt.b        = bNeg ? -opB : opB;
		// Quotient and product take the xor of the signs; remainder follows the dividend
		nxt.resSign  = aNeg ^ bNeg;
		nxt.remSign  = aNeg;
		nxt.takeHigh = dec.takeHigh;
		nxt.takeRem  = dec.takeRem;
		nxt.isSigned = dec.isSigned;
		nxt.divZero  = (opB == '0);
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			prep <= '0;
		else if (prepLoad)
			prep <= nxt;
	end

	assign prepZero = (prep.kind == K_DIV) && prep.divZero;

endmodule

// ==== mdMultiplier.sv ====
// Pipelined magnitude multiplier with sign fixup and overflow detection
// Accumulates 16-by-32 partial products over the register stages

`timescale 1ns/1ns
`include "md_cfg.svh"

module mdMultiplier (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  mulLoad,
	input  mdDataPkg::mdPrepared prep,
	output mdDataPkg::mdResult   mulRes
);
	localparam int W = `MD_WIDTH;
	localparam int Stages = `MD_MUL_STAGES;
	localparam int Chunks = W / 16;

	// One pipeline slot with its own tags, so several products can be in flight
	typedef struct packed {
		logic           neg;
		logic           high;
		logic           sgnd;
		logic [W-1:0]   a;
		logic [W-1:0]   b;
		logic [2*W-1:0] acc;
	} mulStage;

	mulStage          stg [Stages];
	logic [Stages-2:0] vld;
	logic [2*W-1:0]   prod;
	logic [W-1:0]     hi;
	logic [W-1:0]     lo;

	// Product of one 16-bit chunk of a with all of b, moved to its weight
	function automatic logic [2*W-1:0] partial(input logic [W-1:0] a,
		input logic [W-1:0] b, input int idx);
		logic [2*W-1:0] pp;
		pp = (2*W)'(a[idx*16 +: 16]) * (2*W)'(b);
		return pp << (16 * idx);
	endfunction

	// Valid chain that moves each slot forward one stage per cycle
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			vld <= '0;
		else
			vld <= {vld[Stages-3:0], mulLoad};
	end

	always_ff @(posedge clk)
	begin
		if (mulLoad)
			stg[0] <= '{prep.resSign, prep.takeHigh, prep.isSigned, prep.a, prep.b, '0};
		for (int k = 1; k < Stages; k++)
		begin
			// A stage holds its value until new data arrives from behind it
			if (vld[k-1])
			begin
				stg[k] <= stg[k-1];
				if (k <= Chunks)
					stg[k].acc <= stg[k-1].acc + partial(stg[k-1].a, stg[k-1].b, k - 1);
			end
		end
	end

	// ====================
	// Output fixup
	// ====================

	assign prod = stg[Stages-1].neg ? -stg[Stages-1].acc : stg[Stages-1].acc;
	assign hi   = prod[2*W-1:W];
	assign lo   = prod[W-1:0];

	always_comb
	begin
		mulRes.value  = stg[Stages-1].high ? hi : lo;
		// Low-half results overflow when the high half carries information
		if (stg[Stages-1].high)
			mulRes.ovf = 1'b0;
		else if (stg[Stages-1].sgnd)
			mulRes.ovf = (hi != {W{lo[W-1]}});
		else
			mulRes.ovf = (hi != '0);
		mulRes.dvByZr = 1'b0;
	end

endmodule

// ==== mdDivider.sv ====
// Restoring divider producing one quotient bit per step
// Handles divide by zero and applies the quotient and remainder signs

`timescale 1ns/1ns
`include "md_cfg.svh"

module mdDivider (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  divLoad,
	input  logic                  divStep,
	input  mdDataPkg::mdPrepared prep,
	output mdDataPkg::mdResult   divRes
);
	localparam int W = `MD_WIDTH;

	// Partial remainder, dividend shifting into quotient, and divisor
	logic [W-1:0] rem;
	logic [W-1:0] quo;
	logic [W-1:0] dvs;
	logic [W:0]   shifted;
	logic [W:0]   diff;
	logic [W-1:0] qVal;
	logic [W-1:0] rMag;
	logic [W-1:0] rVal;

	// Bring down the next dividend bit and try to subtract the divisor
	assign shifted = {rem, quo[W-1]};
	assign diff    = shifted - {1'b0, dvs};

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			rem <= '0;
			quo <= '0;
			dvs <= '0;
		end
		else if (divLoad)
		begin
			rem <= '0;
			quo <= prep.a;
			dvs <= prep.b;
		end
		else if (divStep)
		begin
			// A borrow means the divisor did not fit, so the remainder is restored
			if (!diff[W])
			begin
				rem <= diff[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end
			else
			begin
				rem <= shifted[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

	// ====================
	// Sign fixup
	// ====================

	// Divide by zero yields all ones and hands back the original dividend
	always_comb
	begin
		if (prep.divZero)
			qVal = '1;
		else if (prep.resSign)
			qVal = -quo;
		else
			qVal = quo;
		rMag = prep.divZero ? prep.a : rem;
		rVal = prep.remSign ? -rMag : rMag;
	end

	// The minimum over minus one falls out naturally as the wrapped quotient
	assign divRes.value  = prep.takeRem ? rVal : qVal;
	assign divRes.ovf    = 1'b0;
	assign divRes.dvByZr = prep.divZero;

endmodule

// ==== mdUnit.sv ====
// Multi-cycle multiply/divide unit for the execute stage
// Joins the sequencer, counter, operand prep and both datapaths

`timescale 1ns/1ns

module mdUnit (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  start,
	input  mdDataPkg::mdOperands ops,
	output logic                  busy,
	output logic                  done,
	output mdDataPkg::mdResult   res
);
	import mdIsaPkg::*;
	import mdDataPkg::*;

	// ====================
	// Control strobes
	// ====================

	logic       prepLoad;
	logic       cntLoad;
	logic       mulLoad;
	logic       divLoad;
	logic       divStep;
	logic [5:0] cntInit;
	logic       last;
	logic       prepZero;

	// Prepared operands and the two candidate results
	mdPrepared  prep;
	mdResult    mulRes;
	mdResult    divRes;

	mdSequencer uSeq (
		.clk      (clk),
		.arstN    (arstN),
		.start    (start),
		.prepZero (prepZero),
		.kind     (prep.kind),
		.last     (last),
		.prepLoad (prepLoad),
		.cntLoad  (cntLoad),
		.mulLoad  (mulLoad),
		.divLoad  (divLoad),
		.divStep  (divStep),
		.cntInit  (cntInit),
		.busy     (busy),
		.done     (done)
	);

	mdCycleCounter uCnt (
		.clk     (clk),
		.arstN   (arstN),
		.cntLoad (cntLoad),
		.cntInit (cntInit),
		.last    (last)
	);

	mdOperandPrep uPrep (
		.clk      (clk),
		.arstN    (arstN),
		.prepLoad (prepLoad),
		.ops      (ops),
		.prep     (prep),
		.prepZero (prepZero)
	);

	mdMultiplier uMul (
		.clk     (clk),
		.arstN   (arstN),
		.mulLoad (mulLoad),
		.prep    (prep),
		.mulRes  (mulRes)
	);

	mdDivider uDiv (
		.clk     (clk),
		.arstN   (arstN),
		.divLoad (divLoad),
		.divStep (divStep),
		.prep    (prep),
		.divRes  (divRes)
	);

	// The stored kind stays put for the whole operation, so it picks the result
	assign res = (prep.kind == K_DIV) ? divRes : mulRes;

endmodule

// ==== mdClockGen.sv ====
// Testbench clock source for the multiply/divide unit
// Free-running clock with a 20 ns period

`timescale 1ns/1ns

module mdClockGen (
	output logic clk
);
	localparam int HalfPeriod = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#HalfPeriod clk = ~clk;
	end

endmodule

// ==== mdUnit_props.sv ====
// Protocol assertions for the multiply/divide unit
// Bound to the top level to watch start, busy and done

`timescale 1ns/1ns

module mdUnit_props (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic busy,
	input logic done
);

	// Number of assertion failures seen so far in the run
	int assertFails = 0;

	// Done is a single-cycle strobe
	doneOnePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else
		begin
			assertFails++;
			$error("done stayed high for more than one cycle");
		end

	// A result only closes an operation that was already running the cycle before
	doneAfterBusy: assert property (@(posedge clk) disable iff (!arstN) done |-> $past(busy))
		else
		begin
			assertFails++;
			$error("done seen without an operation in progress");
		end

	// An accepted start makes the unit busy on the next cycle
	startGoesBusy: assert property (@(posedge clk) disable iff (!arstN)
		(start && !busy) |=> busy)
		else
		begin
			assertFails++;
			$error("start while idle did not raise busy");
		end

	// The sequencer comes out of reset idle
	idleAfterReset: assert property (@(posedge clk) $rose(arstN) |-> (!busy && !done))
		else
		begin
			assertFails++;
			$error("busy or done high right after reset");
		end

endmodule

bind mdUnit mdUnit_props uProps (
	.clk   (clk),
	.arstN (arstN),
	.start (start),
	.busy  (busy),
	.done  (done)
);

// ==== mdUnit_tb.sv ====
// Testbench for the multiply/divide unit
// Runs file vectors, random unsigned high multiplies and a start-while-busy case

`timescale 1ns/1ns
`include "md_cfg.svh"

module mdUnit_tb;
	import mdIsaPkg::*;
	import mdDataPkg::*;

	localparam int TimeoutCycles = 60;

	logic      clk;
	logic      arstN;
	logic      start;
	mdOperands ops;
	logic      busy;
	logic      done;
	mdResult   res;

	int testCount;
	int failCount;
	int seed;

	mdClockGen uClk (
		.clk (clk)
	);

	mdUnit uut (
		.clk   (clk),
		.arstN (arstN),
		.start (start),
		.ops   (ops),
		.busy  (busy),
		.done  (done),
		.res   (res)
	);

	// ====================
	// Helpers
	// ====================

	// Latency from the sampling edge of start to the done cycle
	function automatic int expectedCycles(input logic [31:0] instr, input logic expDvz);
		logic [3:0] opc;
		logic [3:0] fn;
		logic       isDiv;
		opc   = instr[31:28];
		fn    = instr[27:24];
		isDiv = (opc == OP_DIVI) || (opc == OP_DIVUI) || (opc == OP_R2 && fn >= F_DIV);
		if (isDiv && expDvz)
			return 2;
		else if (isDiv)
			return `MD_WIDTH + 2;
		return `MD_MUL_STAGES + 2;
	endfunction

	// Presents one operation on the falling edge, start is dropped by the wait
	task automatic issueOp(input logic [31:0] instr, input logic [31:0] a,
		input logic [31:0] b);
		@(negedge clk);
		ops.instr = instr;
		ops.a     = a;
		ops.b     = b;
		start     = 1'b1;
	endtask

	// Counts falling edges until done shows up or the budget runs out
	task automatic awaitDone(inout int cycles, output logic seen);
		seen = done;
		while (!seen && cycles < TimeoutCycles)
		begin
			@(negedge clk);
			start = 1'b0;
			cycles++;
			seen = done;
		end
	endtask

	task automatic checkResult(input string name, input logic [31:0] expVal,
		input logic expOvf, input logic expDvz, input int expCyc, input int cycles,
		input logic seen, output logic bad);
		bad = 1'b0;
		if (!seen)
		begin
			$display("%s: no done within %0d cycles of start", name, TimeoutCycles);
			bad = 1'b1;
		end
		else
		begin
			if (cycles != expCyc)
			begin
				$display("%s: done came after %0d cycles instead of %0d", name, cycles, expCyc);
				bad = 1'b1;
			end
			if (res.value !== expVal || res.ovf !== expOvf || res.dvByZr !== expDvz)
			begin
				$display("[ERROR] %s expected %h ovf %b dvByZr %b, actual %h ovf %b dvByZr %b",
					name, expVal, expOvf, expDvz, res.value, res.ovf, res.dvByZr);
				bad = 1'b1;
			end
		end
	endtask

	// One summary line per finished test
	task automatic recordTest(input string name, input logic bad);
		testCount++;
		if (bad)
			failCount++;
		else
			$display("[PASS] %s", name);
	endtask

	task automatic runOperation(input string name, input logic [31:0] instr,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] expVal,
		input logic expOvf, input logic expDvz);
		int   cycles;
		logic seen;
		logic bad;
		cycles = 0;
		issueOp(instr, a, b);
		awaitDone(cycles, seen);
		checkResult(name, expVal, expOvf, expDvz, expectedCycles(instr, expDvz),
			cycles, seen, bad);
		recordTest(name, bad);
	endtask

	// ====================
	// Test groups
	// ====================

	// Each line holds name, instruction, a, b, value, ovf and dvByZr
	task automatic runFileVectors();
		int          fd;
		int          n;
		logic        more;
		string       name;
		string       rest;
		logic [31:0] instr;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expVal;
		logic [31:0] expOvf;
		logic [31:0] expDvz;
		fd = $fopen("mdUnit_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test vector file mdUnit_testdata.txt");
			failCount++;
			return;
		end
		more = 1'b1;
		while (more)
		begin
			n = $fscanf(fd, "%s", name);
			if (n != 1)
				more = 1'b0;
			else if (name.getc(0) == "#")
				n = $fgets(rest, fd);
			else
			begin
				n = $fscanf(fd, "%h %h %h %h %h %h", instr, a, b, expVal, expOvf, expDvz);
				if (n != 6)
				begin
					$display("vector %s in mdUnit_testdata.txt is incomplete", name);
					failCount++;
					more = 1'b0;
				end
				else
					runOperation(name, instr, a, b, expVal, expOvf[0], expDvz[0]);
			end
		end
		$fclose(fd);
	endtask

	// Unsigned high multiply against a full 64-bit product
	task automatic runRandomMulhu(input int count);
		logic [31:0] ra;
		logic [31:0] rb;
		logic [63:0] prod;
		for (int i = 0; i < count; i++)
		begin
			ra   = $random(seed);
			rb   = $random(seed);
			prod = 64'(ra) * 64'(rb);
			runOperation($sformatf("mulhu_rand%0d", i), {OP_R2, F_MULHU, 24'h0}, ra, rb,
				prod[63:32], 1'b0, 1'b0);
		end
	endtask

	// A second start during a divide must be dropped without a trace
	task automatic runStartWhileBusy();
		int   cycles;
		int   extraDone;
		logic seen;
		logic bad;
		logic busyLow;
		cycles  = 0;
		busyLow = 1'b0;
		issueOp({OP_R2, F_DIVU, 24'h0}, 32'd100, 32'd7);
		repeat (4)
		begin
			@(negedge clk);
			start = 1'b0;
			cycles++;
		end
		if (!busy)
		begin
			$display("busy_start: busy was low while a divide was running");
			busyLow = 1'b1;
		end
		ops.instr = {OP_R2, F_MUL, 24'h0};
		ops.a     = 32'd3;
		ops.b     = 32'd3;
		start     = 1'b1;
		awaitDone(cycles, seen);
		checkResult("busy_start", 32'd14, 1'b0, 1'b0, `MD_WIDTH + 2, cycles, seen, bad);
		if (busyLow)
			bad = 1'b1;
		extraDone = 0;
		repeat (40)
		begin
			@(negedge clk);
			if (done)
				extraDone++;
		end
		if (extraDone != 0)
		begin
			$display("busy_start: %0d extra done strobes after the first", extraDone);
			bad = 1'b1;
		end
		// The dropped start must not leave the unit running after its only done
		if (busy)
		begin
			$display("busy_start: busy still high long after the only done");
			bad = 1'b1;
		end
		recordTest("busy_start", bad);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial
	begin
		testCount = 0;
		failCount = 0;
		seed      = 19;
		arstN     = 1'b0;
		start     = 1'b0;
		ops       = '0;
		repeat (8)
			@(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		if (busy || done)
		begin
			$display("reset_idle: busy or done high after reset");
			recordTest("reset_idle", 1'b1);
		end
		else
			recordTest("reset_idle", 1'b0);

		runFileVectors();
		runStartWhileBusy();
		runRandomMulhu(4);

		$display("%0d tests run, %0d passed, %0d failed, %0d assertion failures", testCount,
			testCount - failCount, failCount, uut.uProps.assertFails);
		if (failCount == 0 && uut.uProps.assertFails == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== mdUnit_testdata.txt ====
# name instr a b value ovf dvByZr, every field after the name in hex
mul_pos     00000000 00000007 00000006 0000002A 0 0
mul_neg     00000000 FFFFFFFD 00000005 FFFFFFF1 0 0
mul_ovf     00000000 00010000 00010000 00000000 1 0
mulh_min    01000000 80000000 80000000 40000000 0 0
mulh_neg    01000000 FFFFFFFF 00000002 FFFFFFFF 0 0
mulhu_max   02000000 FFFFFFFF FFFFFFFF FFFFFFFE 0 0
muli_neg    1FFFFFFC 00000064 00000000 FFFFFE70 0 0
muli_ovf    10100000 00001000 00000000 00000000 1 0
mului_ovf   2FFFFFFF 00000100 00000000 FFFFFF00 1 0
mului_big   2FFFFFFF 00000010 00000000 FFFFFFF0 0 0
div_neg     03000000 FFFFFFF9 00000002 FFFFFFFD 0 0
divu_big    04000000 FFFFFFF9 00000002 7FFFFFFC 0 0
rem_neg     05000000 FFFFFFF9 00000002 FFFFFFFF 0 0
remu_big    06000000 FFFFFFF9 00000010 00000009 0 0
div_min     03000000 80000000 FFFFFFFF 80000000 0 0
rem_min     05000000 80000000 FFFFFFFF 00000000 0 0
divi_neg    3FFFFFFD 00000064 00000000 FFFFFFDF 0 0
divui_small 40000007 00000064 00000000 0000000E 0 0
div_zero    03000000 00001234 00000000 FFFFFFFF 0 1
rem_zero    05000000 FFFFFF00 00000000 FFFFFF00 0 1
divui_zero  40000000 00000005 00000000 FFFFFFFF 0 1

// ==== vlog.f ====
+incdir+.
mdIsaPkg.sv
mdDataPkg.sv
mdSequencer.sv
mdCycleCounter.sv
mdOperandPrep.sv
mdMultiplier.sv
mdDivider.sv
mdUnit.sv
mdClockGen.sv
mdUnit_props.sv
mdUnit_tb.sv
